//--- iq_settings.svh
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// ----------------------------------------------------------
// queue geometry
// ----------------------------------------------------------
`define IQ_DEPTH        4                       // slots, slot 0 is oldest
`define IQ_ROB_DEPTH    16                      // rob entries

// ----------------------------------------------------------
// field widths
// ----------------------------------------------------------
`define IQ_TAG_W        $clog2(`IQ_ROB_DEPTH)   // one tag per rob entry
`define IQ_WORD_W       32                      // operands and immediates
`define IQ_PC_W         32

// two source operands per instruction
`define IQ_NUM_SRC      2

`endif

//--- iq_pkg.sv
`default_nettype none

`include "iq_settings.svh"

package iq_pkg;

    typedef logic [`IQ_TAG_W-1:0]          rob_tag_t;   // physical destination
    typedef logic [`IQ_WORD_W-1:0]         word_t;
    typedef logic [`IQ_PC_W-1:0]           pc_t;
    typedef logic [$clog2(`IQ_DEPTH)-1:0]  slot_idx_t;

    // opcode travels as payload only
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SLL = 4'h5,
        OP_LW  = 4'h6,
        OP_JAL = 4'h7
    } iq_op_e;

    // per-slot action at the next edge
    typedef enum logic [1:0] {
        CMD_HOLD  = 2'd0,   // keep contents
        CMD_LOAD  = 2'd1,   // take dispatched instruction
        CMD_SHIFT = 2'd2,   // take slot i+1
        CMD_CLEAR = 2'd3    // back to reset values
    } slot_cmd_e;

endpackage

`default_nettype wire

//--- iq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module iq_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dispatch_en,
    input  wire                     flush,
    input  wire                     fu_ready,
    input  wire [`IQ_DEPTH-1:0]     slot_ready,
    output logic [`IQ_DEPTH-1:0]    slot_valid,
    output iq_pkg::slot_cmd_e       slot_cmd [`IQ_DEPTH],
    output iq_pkg::slot_idx_t       issue_idx,
    output logic                    issue_en,
    output logic                    iq_full,
    output logic                    write_en
);
    import iq_pkg::*;

    logic [`IQ_DEPTH:0] occ_ptr;    // one-hot count of used slots
    logic [`IQ_DEPTH:0] valid_ext;  // slot_valid with an empty slot past the end
    logic               any_ready;

    // ----------------------------------------------------------
    // occupancy
    // ----------------------------------------------------------
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            seen          = seen | occ_ptr[i];
            slot_valid[i] = !seen;          // valid below the free marker
        end
    end

    assign valid_ext = {1'b0, slot_valid};
    assign iq_full   = occ_ptr[`IQ_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_ptr <= 'b1;
        end else if (flush) begin
            occ_ptr <= 'b1;                 // queue emptied
        end else if (write_en && !issue_en) begin
            occ_ptr <= occ_ptr << 1;
        end else if (issue_en && !write_en) begin
            occ_ptr <= occ_ptr >> 1;
        end
    end

    // ----------------------------------------------------------
    // oldest-ready select
    // ----------------------------------------------------------
    always_comb begin
        issue_idx = '0;
        any_ready = 1'b0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (slot_valid[i] && slot_ready[i]) begin
                issue_idx = slot_idx_t'(i);     // lowest index wins
                any_ready = 1'b1;
            end
        end
    end

    assign issue_en = any_ready && fu_ready && !flush;
    assign write_en = dispatch_en && !iq_full && !flush;

    // ----------------------------------------------------------
    // per-slot commands
    // ----------------------------------------------------------
    // on issue everything at or above issue_idx moves down one slot
    // and a dispatch lands right behind the survivors
    always_comb begin
        logic load_here;
        logic shift_here;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            load_here  = write_en && (issue_en ? occ_ptr[i+1] : occ_ptr[i]);
            shift_here = issue_en && (int'(issue_idx) <= i);
            if (flush) begin
                slot_cmd[i] = CMD_CLEAR;
            end else if (load_here) begin
                slot_cmd[i] = CMD_LOAD;
            end else if (shift_here) begin
                slot_cmd[i] = valid_ext[i+1] ? CMD_SHIFT : CMD_CLEAR;   // vacated top
            end else begin
                slot_cmd[i] = CMD_HOLD;
            end
        end
    end

    // single free marker keeps valid slots packed from slot 0
    a_occ_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(occ_ptr));

endmodule

`default_nettype wire

//--- iq_wakeup.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module iq_wakeup (
    input  wire [`IQ_DEPTH-1:0]         slot_valid,
    input  wire iq_pkg::rob_tag_t       slot_src_tag     [`IQ_DEPTH][`IQ_NUM_SRC],
    input  wire [`IQ_NUM_SRC-1:0]       slot_src_pending [`IQ_DEPTH],
    input  wire iq_pkg::rob_tag_t       in_rs1_tag,
    input  wire iq_pkg::rob_tag_t       in_rs2_tag,
    input  wire                         in_rs1_pending,
    input  wire                         in_rs2_pending,
    input  wire                         wb_alu_valid,
    input  wire                         wb_load_valid,
    input  wire iq_pkg::rob_tag_t       wb_alu_tag,
    input  wire iq_pkg::rob_tag_t       wb_load_tag,
    input  wire iq_pkg::word_t          wb_alu_data,
    input  wire iq_pkg::word_t          wb_load_data,
    output logic [`IQ_NUM_SRC-1:0]      slot_hit      [`IQ_DEPTH],
    output iq_pkg::word_t               slot_hit_data [`IQ_DEPTH][`IQ_NUM_SRC],
    output logic [`IQ_NUM_SRC-1:0]      in_hit,
    output iq_pkg::word_t               in_hit_data   [`IQ_NUM_SRC]
);
    import iq_pkg::*;

    rob_tag_t   in_tag [`IQ_NUM_SRC];
    logic [`IQ_NUM_SRC-1:0] in_pend;

    assign in_tag[0] = in_rs1_tag;
    assign in_tag[1] = in_rs2_tag;
    assign in_pend   = {in_rs2_pending, in_rs1_pending};

    function automatic logic tag_match(input logic armed, input rob_tag_t src,
                                       input rob_tag_t wb_tag);
        return armed && (src == wb_tag);
    endfunction

    // alu bus has priority on a shared tag
    function automatic word_t pick_data(input logic alu_hit, input logic load_hit);
        word_t data;
        data = '0;
        if (alu_hit) begin
            data = wb_alu_data;
        end else if (load_hit) begin
            data = wb_load_data;
        end
        return data;
    endfunction

    // ----------------------------------------------------------
    // stored sources, invalid slots never hit
    // ----------------------------------------------------------
    always_comb begin
        logic armed;
        logic alu_hit;
        logic load_hit;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                armed    = slot_valid[i] && slot_src_pending[i][s];
                alu_hit  = tag_match(armed && wb_alu_valid, slot_src_tag[i][s], wb_alu_tag);
                load_hit = tag_match(armed && wb_load_valid, slot_src_tag[i][s], wb_load_tag);
                slot_hit[i][s]      = alu_hit || load_hit;
                slot_hit_data[i][s] = pick_data(alu_hit, load_hit);
            end
        end
    end

    // ----------------------------------------------------------
    // sources of the instruction being dispatched
    // ----------------------------------------------------------
    always_comb begin
        logic alu_hit;
        logic load_hit;
        for (int s = 0; s < `IQ_NUM_SRC; s++) begin
            alu_hit        = tag_match(in_pend[s] && wb_alu_valid, in_tag[s], wb_alu_tag);
            load_hit       = tag_match(in_pend[s] && wb_load_valid, in_tag[s], wb_load_tag);
            in_hit[s]      = alu_hit || load_hit;
            in_hit_data[s] = pick_data(alu_hit, load_hit);
        end
    end

endmodule

`default_nettype wire

//--- iq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module iq_entry_array (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire iq_pkg::slot_cmd_e      slot_cmd [`IQ_DEPTH],
    input  wire iq_pkg::slot_idx_t      issue_idx,
    // dispatch
    input  wire iq_pkg::iq_op_e         id_op,
    input  wire iq_pkg::pc_t            id_pc,
    input  wire iq_pkg::word_t          id_imm,
    input  wire iq_pkg::rob_tag_t       id_dst_tag,
    input  wire iq_pkg::rob_tag_t       rs1_tag,
    input  wire iq_pkg::rob_tag_t       rs2_tag,
    input  wire                         rs1_pending,
    input  wire                         rs2_pending,
    input  wire iq_pkg::word_t          rs1_value,
    input  wire iq_pkg::word_t          rs2_value,
    // wakeup
    input  wire [`IQ_NUM_SRC-1:0]       slot_hit      [`IQ_DEPTH],
    input  wire iq_pkg::word_t          slot_hit_data [`IQ_DEPTH][`IQ_NUM_SRC],
    input  wire [`IQ_NUM_SRC-1:0]       in_hit,
    input  wire iq_pkg::word_t          in_hit_data   [`IQ_NUM_SRC],
    // status
    output logic [`IQ_DEPTH-1:0]        slot_ready,
    output iq_pkg::rob_tag_t            slot_src_tag     [`IQ_DEPTH][`IQ_NUM_SRC],
    output logic [`IQ_NUM_SRC-1:0]      slot_src_pending [`IQ_DEPTH],
    // issue payload
    output iq_pkg::iq_op_e              issue_op,
    output iq_pkg::pc_t                 issue_pc,
    output iq_pkg::word_t               issue_imm,
    output iq_pkg::word_t               issue_rs1_value,
    output iq_pkg::word_t               issue_rs2_value,
    output iq_pkg::rob_tag_t            issue_dst_tag
);
    import iq_pkg::*;

    // ----------------------------------------------------------
    // slot storage
    // ----------------------------------------------------------
    rob_tag_t               src_tag_q  [`IQ_DEPTH][`IQ_NUM_SRC];
    logic [`IQ_NUM_SRC-1:0] src_pend_q [`IQ_DEPTH];    // 1 = waiting on tag
    word_t                  src_val_q  [`IQ_DEPTH][`IQ_NUM_SRC];
    iq_op_e                 op_q       [`IQ_DEPTH];
    pc_t                    pc_q       [`IQ_DEPTH];
    word_t                  imm_q      [`IQ_DEPTH];
    rob_tag_t               dst_q      [`IQ_DEPTH];

    rob_tag_t               id_tag [`IQ_NUM_SRC];
    logic [`IQ_NUM_SRC-1:0] id_pend;
    word_t                  id_val [`IQ_NUM_SRC];
    logic [`IQ_DEPTH-1:0]   load_vec;

    assign id_tag[0] = rs1_tag;
    assign id_tag[1] = rs2_tag;
    assign id_pend   = {rs2_pending, rs1_pending};
    assign id_val[0] = rs1_value;
    assign id_val[1] = rs2_value;

    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_slot
        localparam int NXT = (i < `IQ_DEPTH - 1) ? i + 1 : i;   // younger neighbour

        // tags and pending bits
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                    src_tag_q[i][s] <= '0;
                end
                src_pend_q[i] <= '0;
            end else begin
                for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                    case (slot_cmd[i])
                        CMD_LOAD: begin
                            src_tag_q[i][s]  <= id_tag[s];
                            src_pend_q[i][s] <= id_pend[s] && !in_hit[s];
                        end
                        CMD_SHIFT: begin     // neighbour's wakeup travels with it
                            src_tag_q[i][s]  <= src_tag_q[NXT][s];
                            src_pend_q[i][s] <= src_pend_q[NXT][s] && !slot_hit[NXT][s];
                        end
                        CMD_CLEAR: begin
                            src_tag_q[i][s]  <= '0;
                            src_pend_q[i][s] <= 1'b0;
                        end
                        default: begin
                            src_pend_q[i][s] <= src_pend_q[i][s] && !slot_hit[i][s];
                        end
                    endcase
                end
            end
        end

        // payload and operand values
        always_ff @(posedge clk) begin
            case (slot_cmd[i])
                CMD_LOAD: begin
                    op_q[i]  <= id_op;
                    pc_q[i]  <= id_pc;
                    imm_q[i] <= id_imm;
                    dst_q[i] <= id_dst_tag;
                    for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                        src_val_q[i][s] <= in_hit[s] ? in_hit_data[s] : id_val[s];
                    end
                end
                CMD_SHIFT: begin
                    op_q[i]  <= op_q[NXT];
                    pc_q[i]  <= pc_q[NXT];
                    imm_q[i] <= imm_q[NXT];
                    dst_q[i] <= dst_q[NXT];
                    for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                        src_val_q[i][s] <= slot_hit[NXT][s] ? slot_hit_data[NXT][s]
                                                            : src_val_q[NXT][s];
                    end
                end
                CMD_HOLD: begin
                    for (int s = 0; s < `IQ_NUM_SRC; s++) begin
                        if (slot_hit[i][s]) begin
                            src_val_q[i][s] <= slot_hit_data[i][s];
                        end
                    end
                end
                default: ;  // cleared slot, stale payload
            endcase
        end

        assign slot_ready[i] = ~|src_pend_q[i];
        assign load_vec[i]   = (slot_cmd[i] == CMD_LOAD);
    end

    assign slot_src_tag     = src_tag_q;
    assign slot_src_pending = src_pend_q;

    // ----------------------------------------------------------
    // issue mux
    // ----------------------------------------------------------
    assign issue_op        = op_q[issue_idx];
    assign issue_pc        = pc_q[issue_idx];
    assign issue_imm       = imm_q[issue_idx];
    assign issue_dst_tag   = dst_q[issue_idx];
    assign issue_rs1_value = src_val_q[issue_idx][0];
    assign issue_rs2_value = src_val_q[issue_idx][1];

    a_single_load: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(load_vec) <= 1);

endmodule

`default_nettype wire

//--- issue_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module issue_queue_top (
    input  wire                     clk,
    input  wire                     rst_n,
    // dispatch
    input  wire                     dispatch_en,
    input  wire iq_pkg::iq_op_e     id_op,
    input  wire iq_pkg::pc_t        id_pc,
    input  wire iq_pkg::word_t      id_imm,
    input  wire iq_pkg::rob_tag_t   id_dst_tag,
    input  wire iq_pkg::rob_tag_t   rs1_tag,
    input  wire iq_pkg::rob_tag_t   rs2_tag,
    input  wire                     rs1_pending,
    input  wire                     rs2_pending,
    input  wire iq_pkg::word_t      rs1_value,
    input  wire iq_pkg::word_t      rs2_value,
    // writeback buses
    input  wire                     wb_alu_valid,
    input  wire iq_pkg::rob_tag_t   wb_alu_tag,
    input  wire iq_pkg::word_t      wb_alu_data,
    input  wire                     wb_load_valid,
    input  wire iq_pkg::rob_tag_t   wb_load_tag,
    input  wire iq_pkg::word_t      wb_load_data,
    input  wire                     flush,      // taken branch or exception
    input  wire                     fu_ready,
    // issue
    output logic                    issue_en,
    output iq_pkg::iq_op_e          issue_op,
    output iq_pkg::pc_t             issue_pc,
    output iq_pkg::word_t           issue_imm,
    output iq_pkg::word_t           issue_rs1_value,
    output iq_pkg::word_t           issue_rs2_value,
    output iq_pkg::rob_tag_t        issue_dst_tag,
    output logic                    iq_full
);
    import iq_pkg::*;

    logic [`IQ_DEPTH-1:0]   slot_valid;
    logic [`IQ_DEPTH-1:0]   slot_ready;
    slot_cmd_e              slot_cmd [`IQ_DEPTH];
    slot_idx_t              issue_idx;

    rob_tag_t               slot_src_tag     [`IQ_DEPTH][`IQ_NUM_SRC];
    logic [`IQ_NUM_SRC-1:0] slot_src_pending [`IQ_DEPTH];
    logic [`IQ_NUM_SRC-1:0] slot_hit         [`IQ_DEPTH];
    word_t                  slot_hit_data    [`IQ_DEPTH][`IQ_NUM_SRC];
    logic [`IQ_NUM_SRC-1:0] in_hit;
    word_t                  in_hit_data      [`IQ_NUM_SRC];

    iq_ctrl u_ctrl (
        .clk, .rst_n, .dispatch_en, .flush, .fu_ready, .slot_ready,
        .slot_valid, .slot_cmd, .issue_idx, .issue_en, .iq_full, .write_en()
    );

    iq_wakeup u_wakeup (
        .slot_valid, .slot_src_tag, .slot_src_pending,
        .in_rs1_tag(rs1_tag), .in_rs2_tag(rs2_tag),
        .in_rs1_pending(rs1_pending), .in_rs2_pending(rs2_pending),
        .wb_alu_valid, .wb_load_valid, .wb_alu_tag, .wb_load_tag,
        .wb_alu_data, .wb_load_data,
        .slot_hit, .slot_hit_data, .in_hit, .in_hit_data
    );

    iq_entry_array u_array (
        .clk, .rst_n, .slot_cmd, .issue_idx,
        .id_op, .id_pc, .id_imm, .id_dst_tag, .rs1_tag, .rs2_tag,
        .rs1_pending, .rs2_pending, .rs1_value, .rs2_value,
        .slot_hit, .slot_hit_data, .in_hit, .in_hit_data,
        .slot_ready, .slot_src_tag, .slot_src_pending,
        .issue_op, .issue_pc, .issue_imm, .issue_rs1_value, .issue_rs2_value,
        .issue_dst_tag
    );

endmodule

`default_nettype wire

//--- tb_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_queue;
    import iq_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          RESET_CYCLES   = 8;
    localparam string       TRACE_FILE     = "iq_trace.txt";
    localparam int          TIMEOUT_MARGIN = 20;
    localparam int          NUM_FIELDS     = 26;        // words per trace line
    localparam int          MAX_LINES      = 64;
    localparam logic [31:0] END_MARK       = 32'hffff_ffff;
    localparam int          NUM_TAGS       = 2 ** $bits(rob_tag_t);

    logic       clk;
    logic       rst_n;
    logic       dispatch_en;
    iq_op_e     id_op;
    pc_t        id_pc;
    word_t      id_imm;
    rob_tag_t   id_dst_tag;
    rob_tag_t   rs1_tag;
    rob_tag_t   rs2_tag;
    logic       rs1_pending;
    logic       rs2_pending;
    word_t      rs1_value;
    word_t      rs2_value;
    logic       wb_alu_valid;
    rob_tag_t   wb_alu_tag;
    word_t      wb_alu_data;
    logic       wb_load_valid;
    rob_tag_t   wb_load_tag;
    word_t      wb_load_data;
    logic       flush;
    logic       fu_ready;
    logic       issue_en;
    iq_op_e     issue_op;
    pc_t        issue_pc;
    word_t      issue_imm;
    word_t      issue_rs1_value;
    word_t      issue_rs2_value;
    rob_tag_t   issue_dst_tag;
    logic       iq_full;

    logic [31:0] trace [NUM_FIELDS * MAX_LINES];
    pc_t         sent_pc  [NUM_TAGS];   // by rob tag of an accepted dispatch
    word_t       sent_imm [NUM_TAGS];
    int          n_lines;
    int          cycle_count = 0;
    int          cycle_limit;
    int          check_count;
    int          error_count;
    int          test_errors;   // mismatches in the running test
    int          tests_run;
    int          tests_failed;

    issue_queue_top dut0 (
        .clk, .rst_n, .dispatch_en, .id_op, .id_pc, .id_imm, .id_dst_tag,
        .rs1_tag, .rs2_tag, .rs1_pending, .rs2_pending, .rs1_value, .rs2_value,
        .wb_alu_valid, .wb_alu_tag, .wb_alu_data,
        .wb_load_valid, .wb_load_tag, .wb_load_data, .flush, .fu_ready,
        .issue_en, .issue_op, .issue_pc, .issue_imm, .issue_rs1_value,
        .issue_rs2_value, .issue_dst_tag, .iq_full
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit from the trace length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // trace driver and checker
    // ------------------------------------------------------------
    task automatic apply_inputs(input int ln);
        int b;
        b = ln * NUM_FIELDS;
        dispatch_en   <= trace[b+1][0];
        id_op         <= iq_op_e'(trace[b+2][3:0]);
        id_pc         <= trace[b+3];
        id_imm        <= trace[b+4];
        id_dst_tag    <= rob_tag_t'(trace[b+5]);
        rs1_tag       <= rob_tag_t'(trace[b+6]);
        rs2_tag       <= rob_tag_t'(trace[b+7]);
        rs1_pending   <= trace[b+8][0];
        rs2_pending   <= trace[b+9][0];
        rs1_value     <= trace[b+10];
        rs2_value     <= trace[b+11];
        wb_alu_valid  <= trace[b+12][0];
        wb_alu_tag    <= rob_tag_t'(trace[b+13]);
        wb_alu_data   <= trace[b+14];
        wb_load_valid <= trace[b+15][0];
        wb_load_tag   <= rob_tag_t'(trace[b+16]);
        wb_load_data  <= trace[b+17];
        flush         <= trace[b+18][0];
        fu_ready      <= trace[b+19][0];
    endtask

    // accepted when dispatch_en is high, the queue is not full and no flush
    task automatic record_dispatch(input int ln);
        int       b;
        rob_tag_t tag;
        b   = ln * NUM_FIELDS;
        tag = rob_tag_t'(trace[b+5]);
        if (trace[b+1][0] && !trace[b+21][0] && !trace[b+18][0]) begin
            sent_pc[tag]  = trace[b+3];
            sent_imm[tag] = trace[b+4];
        end
    endtask

    task automatic compare_value(input int ln, input string name,
                                 input logic [31:0] got, input logic [31:0] want);
        check_count++;
        assert (got === want) else begin
            $display("Mismatch at %0t: line %0d %s is %0h, expected %0h",
                     $time, ln, name, got, want);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int ln);
        int       b;
        rob_tag_t tag;
        b   = ln * NUM_FIELDS;
        tag = rob_tag_t'(trace[b+22]);
        compare_value(ln, "issue_en", 32'(issue_en), trace[b+20]);
        compare_value(ln, "iq_full", 32'(iq_full), trace[b+21]);
        if (trace[b+20][0]) begin          // payload only means something on issue
            compare_value(ln, "issue_dst_tag", 32'(issue_dst_tag), trace[b+22]);
            compare_value(ln, "issue_op", 32'(issue_op), trace[b+23]);
            compare_value(ln, "issue_rs1_value", issue_rs1_value, trace[b+24]);
            compare_value(ln, "issue_rs2_value", issue_rs2_value, trace[b+25]);
            compare_value(ln, "issue_pc", issue_pc, sent_pc[tag]);
            compare_value(ln, "issue_imm", issue_imm, sent_imm[tag]);
        end
    endtask

    function automatic bit ends_test(input int ln);
        if (ln == n_lines - 1) begin
            return 1'b1;
        end
        return trace[(ln + 1) * NUM_FIELDS] != trace[ln * NUM_FIELDS];
    endfunction

    task automatic report_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", num);
        end else begin
            tests_failed++;
            $display("test %0d: %0d mismatches", num, test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        for (int i = 0; i < NUM_FIELDS * MAX_LINES; i++) begin
            trace[i] = END_MARK;
        end
        $readmemh(TRACE_FILE, trace);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace[n_lines * NUM_FIELDS] != END_MARK) begin
            n_lines++;
        end
        cycle_limit  = n_lines + RESET_CYCLES + TIMEOUT_MARGIN;
        check_count  = 0;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;

        rst_n         = 1'b0;
        dispatch_en   = 1'b0;
        id_op         = OP_ADD;
        id_pc         = '0;
        id_imm        = '0;
        id_dst_tag    = '0;
        rs1_tag       = '0;
        rs2_tag       = '0;
        rs1_pending   = 1'b0;
        rs2_pending   = 1'b0;
        rs1_value     = '0;
        rs2_value     = '0;
        wb_alu_valid  = 1'b0;
        wb_alu_tag    = '0;
        wb_alu_data   = '0;
        wb_load_valid = 1'b0;
        wb_load_tag   = '0;
        wb_load_data  = '0;
        flush         = 1'b0;
        fu_ready      = 1'b0;

        if (n_lines == 0) begin
            $display("Trace file %s holds no stimulus lines", TRACE_FILE);
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // drive on the rising edge and sample at the falling edge
        for (int ln = 0; ln < n_lines; ln++) begin
            @(posedge clk);
            apply_inputs(ln);
            @(negedge clk);
            check_outputs(ln);
            record_dispatch(ln);
            if (ends_test(ln)) begin
                report_test(int'(trace[ln * NUM_FIELDS]));
            end
        end

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- iq_trace.txt
// test dis op pc imm dst t1 t2 p1 p2 v1 v2  alu:v tag data  load:v tag data  flush fu_rdy
// expected: issue_en iq_full dst_tag op rs1_value rs2_value, every field in hex
1 1 0 100  0 3 0 0 0 0  11  22   0 0   0   0 0   0   0 1   0 0 0 0   0   0
1 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 3 0  11  22
1 1 6 104 10 5 0 0 0 0 100   8   0 0   0   0 0   0   0 1   0 0 0 0   0   0
1 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 5 6 100   8
2 1 1 108  0 6 9 0 1 0   0   5   0 0   0   0 0   0   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   1 9  a1   0 0   0   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 6 1  a1   5
2 1 2 10c  0 7 0 a 0 1   3   0   0 0   0   0 0   0   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   0 0   0   1 a  b2   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 7 2   3  b2
2 1 3 110  0 8 b b 1 1   0   0   0 0   0   0 0   0   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   1 b  c3   1 b  d4   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 8 3  c3  c3
2 1 4 114  0 9 c 0 1 0   0   7   0 0   0   1 c  e5   0 1   0 0 0 0   0   0
2 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 9 4  e5   7
3 1 0 118  0 1 d 0 1 0   0   1   0 0   0   0 0   0   0 1   0 0 0 0   0   0
3 1 1 11c  0 2 0 0 0 0  21  22   0 0   0   0 0   0   0 1   0 0 0 0   0   0
3 1 2 120  0 3 d 0 1 0   0  31   0 0   0   0 0   0   0 1   1 0 2 1  21  22
3 0 0   0  0 0 0 0 0 0   0   0   1 d  f6   0 0   0   0 1   0 0 0 0   0   0
3 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 1 0  f6   1
3 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 3 2  f6  31
4 1 0 124  0 4 0 0 0 0  40  41   0 0   0   0 0   0   0 0   0 0 0 0   0   0
4 1 1 128  0 5 0 0 0 0  50  51   0 0   0   0 0   0   0 0   0 0 0 0   0   0
4 1 2 12c  0 6 0 0 0 0  60  61   0 0   0   0 0   0   0 0   0 0 0 0   0   0
4 1 3 130  0 7 0 0 0 0  70  71   0 0   0   0 0   0   0 0   0 0 0 0   0   0
4 1 4 134  0 8 0 0 0 0  80  81   0 0   0   0 0   0   0 0   0 1 0 0   0   0
4 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 1 4 0  40  41
4 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 5 1  50  51
4 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 6 2  60  61
4 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 7 3  70  71
4 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   0 0 0 0   0   0
5 1 5 138  0 a e 0 1 0   0   2   0 0   0   0 0   0   0 1   0 0 0 0   0   0
5 1 6 13c  0 b 0 0 0 0  a0  a1   0 0   0   0 0   0   0 1   0 0 0 0   0   0
5 1 7 140  0 c 0 0 0 0  b0  b1   0 0   0   0 0   0   0 1   1 0 b 6  a0  a1
5 1 0 144  0 d 0 f 0 1  c0   0   1 e  77   0 0   0   0 1   1 0 c 7  b0  b1
5 0 0   0  0 0 0 0 0 0   0   0   0 0   0   1 f  99   0 1   1 0 a 5  77   2
5 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 d 0  c0  99
6 1 1 148  0 1 2 0 1 0   0   0   0 0   0   0 0   0   0 1   0 0 0 0   0   0
6 1 2 14c  0 2 0 0 0 0   5   6   0 0   0   0 0   0   0 1   0 0 0 0   0   0
6 1 3 150  0 3 0 0 0 0   7   8   0 0   0   0 0   0   1 1   0 0 0 0   0   0
6 0 0   0  0 0 0 0 0 0   0   0   1 2  44   0 0   0   0 1   0 0 0 0   0   0
6 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   0 0 0 0   0   0
6 1 4 154  0 4 0 0 0 0  12  34   0 0   0   0 0   0   0 1   0 0 0 0   0   0
6 0 0   0  0 0 0 0 0 0   0   0   0 0   0   0 0   0   0 1   1 0 4 4  12  34

//--- flist.f
+incdir+.
iq_pkg.sv
iq_ctrl.sv
iq_wakeup.sv
iq_entry_array.sv
issue_queue_top.sv
tb_issue_queue.sv

//--- Makefile
TOP := tb_issue_queue

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		-f flist.f --top-module issue_queue_top

clean:
	rm -rf obj_dir
